//--- Bender.yml
package:
  name: gat_layer

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - verilog/gat_pkg.sv
      - verilog/weight_loader.sv
      - verilog/feature_bram.sv
      - verilog/spmm_stage.sv
      - verilog/dmvm_stage.sv
      - verilog/coef_bram.sv
      - verilog/gat_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/gat_checker.sv
      - sim/gat_tb.sv

//--- files.f
+incdir+include
verilog/gat_pkg.sv
verilog/weight_loader.sv
verilog/feature_bram.sv
verilog/spmm_stage.sv
verilog/dmvm_stage.sv
verilog/coef_bram.sv
verilog/gat_top.sv
sim/gat_checker.sv
sim/gat_tb.sv

//--- include/gat_cfg.svh
// GAT layer configuration
`ifndef GAT_CFG_SVH
`define GAT_CFG_SVH

// ==================================================
// Graph and feature sizes
// ==================================================
`define GAT_DATA_W        8
`define GAT_FEAT_IN       16
`define GAT_FEAT_OUT      4
`define GAT_TOTAL_NODES   16
`define GAT_MAX_NODES     4

// Memory depths
`define GAT_NNZ_DEPTH     64
`define GAT_WGT_DEPTH     72

// Datapath widths
`define GAT_WH_W          20
`define GAT_COEF_W        24

// Negative scores are divided by 2**shift
`define GAT_LRELU_SHIFT   3

// ==================================================
// Derived widths
// ==================================================
`define GAT_NODE_AW       ($clog2(`GAT_TOTAL_NODES))
`define GAT_NNZ_AW        ($clog2(`GAT_NNZ_DEPTH))
`define GAT_WGT_AW        ($clog2(`GAT_WGT_DEPTH))
`define GAT_COL_W         ($clog2(`GAT_FEAT_IN))
`define GAT_ROW_LEN_W     ($clog2(`GAT_FEAT_IN) + 1)
`define GAT_SG_W          ($clog2(`GAT_MAX_NODES) + 1)

`endif

//--- sim/gat_checker.sv
// GAT ready flag assertions
`timescale 1ns/1ps
`default_nettype none

module gat_checker (
  input wire logic clk,
  input wire logic rst_n,
  input wire logic gat_ready_i
);

  int fail_count = 0;

  // ==================================================
  // Ready flag
  // ==================================================
  // Sticky until the next reset
  ready_sticky: assert property (
    @(posedge clk) disable iff (!rst_n) gat_ready_i |=> gat_ready_i
  ) else begin
    $error("gat_ready_o fell while rst_n was high");
    fail_count++;
  end

  ready_low_after_reset: assert property (
    @(posedge clk) $rose(rst_n) |=> !gat_ready_i
  ) else begin
    $error("gat_ready_o high in the cycle after reset");
    fail_count++;
  end

endmodule

bind gat_top gat_checker u_checker (
  .clk         (clk),
  .rst_n       (rst_n),
  .gat_ready_i (gat_ready_o)
);

`default_nettype wire

//--- sim/gat_tb.sv
// GAT layer testbench
`timescale 1ns/1ps
`default_nettype none

`include "gat_cfg.svh"

module gat_tb;

  localparam int FO  = `GAT_FEAT_OUT;
  localparam int FI  = `GAT_FEAT_IN;
  localparam int NN  = `GAT_TOTAL_NODES;
  localparam int NNZ = `GAT_NNZ_DEPTH;
  // Idle check and three layer runs, each under 300 cycles
  localparam int TIMEOUT_CYCLES = 4000;

  logic                    clk;
  logic                    rst_n;
  gat_pkg::h_wr_t          h_wr;
  gat_pkg::info_wr_t       info_wr;
  gat_pkg::wgt_wr_t        wgt_wr;
  logic                    h_load_done;
  logic                    info_load_done;
  logic                    wgt_load_done;
  logic [`GAT_NODE_AW-1:0] coef_addr;
  gat_pkg::coef_t          coef_data;
  logic                    gat_ready;

  // Host copies of the memory contents
  int     w_ref    [FO][FI];
  int     a_ref    [2*FO];
  int     h_val    [NNZ];
  int     h_col    [NNZ];
  int     row_len  [NN];
  int     sg_size  [NN];
  bit     centre   [NN];
  longint exp_coef [NN];

  logic [15:0] lfsr_state;
  int          cycle_cnt = 0;

  gat_top dut (
    .clk              (clk),
    .rst_n            (rst_n),
    .h_wr_i           (h_wr),
    .info_wr_i        (info_wr),
    .wgt_wr_i         (wgt_wr),
    .h_load_done_i    (h_load_done),
    .info_load_done_i (info_load_done),
    .wgt_load_done_i  (wgt_load_done),
    .coef_addr_i      (coef_addr),
    .coef_data_o      (coef_data),
    .gat_ready_o      (gat_ready)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Done: errors found");
      $fatal(1, "timeout");
    end
  end

  // ==================================================
  // Helpers
  // ==================================================
  // Taps 16, 14, 13, 11
  function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
    lfsr_state = {lfsr_state[14:0], fb};
    return fb;
  endfunction

  function automatic int rand_bits(int n);
    int r;
    r = 0;
    for (int i = 0; i < n; i++) begin
      r = (r << 1) | lfsr_bit();
    end
    return r;
  endfunction

  function automatic int rand_data();
    int v;
    v = rand_bits(8);
    return (v >= 128) ? v - 256 : v;
  endfunction

  function automatic longint wrap_signed(longint v, int w);
    return (v <<< (64 - w)) >>> (64 - w);
  endfunction

  task automatic stop_on_error(string msg);
    $display("%s", msg);
    $display("Done: errors found");
    $fatal(1, "stopped at first error");
  endtask

  // Reference model: WH, left and right scores, centre pairing, leaky ReLU
  function automatic void compute_model();
    longint wh [FO];
    longint left;
    longint right;
    longint centre_left;
    longint sum;
    int     ptr;
    ptr = 0;
    centre_left = 0;
    for (int n = 0; n < NN; n++) begin
      for (int f = 0; f < FO; f++) begin
        wh[f] = 0;
      end
      for (int i = 0; i < row_len[n]; i++) begin
        for (int f = 0; f < FO; f++) begin
          wh[f] += h_val[ptr] * w_ref[f][h_col[ptr]];
        end
        ptr++;
      end
      left = 0;
      right = 0;
      for (int f = 0; f < FO; f++) begin
        wh[f] = wrap_signed(wh[f], `GAT_WH_W);
        left += a_ref[f] * wh[f];
        right += a_ref[FO + f] * wh[f];
      end
      left = wrap_signed(left, `GAT_COEF_W);
      right = wrap_signed(right, `GAT_COEF_W);
      if (centre[n]) begin
        centre_left = left;
      end
      sum = wrap_signed(centre_left + right, `GAT_COEF_W);
      exp_coef[n] = (sum < 0) ? (sum >>> `GAT_LRELU_SHIFT) : sum;
    end
  endfunction

  task automatic clear_rows();
    for (int i = 0; i < NNZ; i++) begin
      h_val[i] = 0;
      h_col[i] = 0;
    end
  endtask

  task automatic apply_reset();
    @(negedge clk);
    rst_n = 1'b0;
    h_wr = '0;
    info_wr = '0;
    wgt_wr = '0;
    h_load_done = 1'b0;
    info_load_done = 1'b0;
    wgt_load_done = 1'b0;
    coef_addr = '0;
    repeat (5) @(negedge clk);
    rst_n = 1'b1;
  endtask

  // All three memories written in parallel, one word per cycle
  task automatic load_memories();
    for (int i = 0; i < `GAT_WGT_DEPTH; i++) begin
      h_wr.en = (i < NNZ);
      h_wr.addr = i[`GAT_NNZ_AW-1:0];
      h_wr.data.val = gat_pkg::data_t'(h_val[i % NNZ]);
      h_wr.data.col = h_col[i % NNZ][`GAT_COL_W-1:0];
      info_wr.en = (i < NN);
      info_wr.addr = i[`GAT_NODE_AW-1:0];
      info_wr.data.row_len = row_len[i % NN][`GAT_ROW_LEN_W-1:0];
      info_wr.data.sg_size = sg_size[i % NN][`GAT_SG_W-1:0];
      info_wr.data.centre = centre[i % NN];
      wgt_wr.en = 1'b1;
      wgt_wr.addr = i[`GAT_WGT_AW-1:0];
      if (i < FO * FI) begin
        wgt_wr.data = gat_pkg::data_t'(w_ref[i / FI][i % FI]);
      end else begin
        wgt_wr.data = gat_pkg::data_t'(a_ref[i - FO * FI]);
      end
      @(negedge clk);
    end
    h_wr.en = 1'b0;
    info_wr.en = 1'b0;
    wgt_wr.en = 1'b0;
  endtask

  task automatic check_coefs();
    gat_pkg::coef_t expected;
    for (int n = 0; n < NN; n++) begin
      coef_addr = n[`GAT_NODE_AW-1:0];
      @(negedge clk);
      expected = gat_pkg::coef_t'(exp_coef[n]);
      assert (coef_data === expected) else
        stop_on_error($sformatf("[ERROR] t=%0t coef_data_o[%0d]: got %0d expected %0d",
                                $time, n, coef_data, expected));
    end
  endtask

  task automatic run_layer();
    apply_reset();
    load_memories();
    h_load_done = 1'b1;
    info_load_done = 1'b1;
    wgt_load_done = 1'b1;
    compute_model();
    while (!gat_ready) begin
      @(negedge clk);
    end
    check_coefs();
  endtask

  // ==================================================
  // Tests
  // ==================================================
  // Empty rows everywhere, so an early start would finish well inside the window
  task automatic test_idle_until_loaded();
    apply_reset();
    load_memories();
    for (int c = 0; c < 200; c++) begin
      wgt_load_done = (c >= 50);
      h_load_done = (c >= 100);
      @(negedge clk);
      assert (gat_ready === 1'b0) else
        stop_on_error($sformatf("[ERROR] t=%0t gat_ready_o: got %b expected 0",
                                $time, gat_ready));
    end
  endtask

  task automatic test_uniform_subgraphs();
    int ptr;
    ptr = 0;
    clear_rows();
    for (int i = 0; i < FO * FI; i++) begin
      w_ref[i / FI][i % FI] = i % 7 + 1;
    end
    for (int i = 0; i < 2 * FO; i++) begin
      a_ref[i] = i % 3 + 1;
    end
    for (int n = 0; n < NN; n++) begin
      row_len[n] = 2;
      sg_size[n] = 4;
      centre[n] = (n % 4 == 0);
      for (int i = 0; i < 2; i++) begin
        h_val[ptr] = (n + i) % 5 + 1;
        h_col[ptr] = (n + 5 * i) % FI;
        ptr++;
      end
    end
    run_layer();
  endtask

  // Sizes 1, 3, 4, 2, 4, 2 with every third row empty
  task automatic test_mixed_subgraphs();
    int sizes [6];
    int ptr;
    int n;
    sizes = '{1, 3, 4, 2, 4, 2};
    ptr = 0;
    n = 0;
    clear_rows();
    for (int i = 0; i < FO * FI; i++) begin
      w_ref[i / FI][i % FI] = i % 9 - 4;
    end
    for (int i = 0; i < 2 * FO; i++) begin
      a_ref[i] = (i % 2 == 1) ? -3 : 2;
    end
    for (int s = 0; s < 6; s++) begin
      for (int m = 0; m < sizes[s]; m++) begin
        centre[n] = (m == 0);
        sg_size[n] = sizes[s];
        row_len[n] = (n % 3 == 1) ? 0 : 3;
        for (int i = 0; i < row_len[n]; i++) begin
          h_val[ptr] = (n * 3 + i) % 11 - 5;
          h_col[ptr] = (n * 7 + i * 3) % FI;
          ptr++;
        end
        n++;
      end
    end
    run_layer();
  endtask

  task automatic test_random_graph();
    int ptr;
    int left_in_sg;
    int size;
    ptr = 0;
    left_in_sg = 0;
    size = 0;
    clear_rows();
    for (int i = 0; i < FO * FI; i++) begin
      w_ref[i / FI][i % FI] = rand_data();
    end
    for (int i = 0; i < 2 * FO; i++) begin
      a_ref[i] = rand_data();
    end
    for (int n = 0; n < NN; n++) begin
      centre[n] = (left_in_sg == 0);
      if (left_in_sg == 0) begin
        size = rand_bits(2) + 1;
        if (size > NN - n) begin
          size = NN - n;
        end
        left_in_sg = size;
      end
      sg_size[n] = size;
      left_in_sg--;
      row_len[n] = rand_bits(2);
      for (int i = 0; i < row_len[n]; i++) begin
        h_val[ptr] = rand_data();
        h_col[ptr] = rand_bits(4);
        ptr++;
      end
    end
    run_layer();
  endtask

  task automatic test_reread_stable();
    gat_pkg::coef_t first;
    for (int n = 0; n < NN; n++) begin
      coef_addr = n[`GAT_NODE_AW-1:0];
      @(negedge clk);
      first = coef_data;
      @(negedge clk);
      assert (coef_data === first) else
        stop_on_error($sformatf("[ERROR] t=%0t coef_data_o[%0d]: got %0d expected %0d",
                                $time, n, coef_data, first));
      assert (gat_ready === 1'b1) else
        stop_on_error($sformatf("[ERROR] t=%0t gat_ready_o: got %b expected 1",
                                $time, gat_ready));
    end
  endtask

  initial begin
    lfsr_state = 16'd83;
    rst_n = 1'b0;
    h_wr = '0;
    info_wr = '0;
    wgt_wr = '0;
    h_load_done = 1'b0;
    info_load_done = 1'b0;
    wgt_load_done = 1'b0;
    coef_addr = '0;
    test_idle_until_loaded();
    test_uniform_subgraphs();
    test_mixed_subgraphs();
    test_random_graph();
    test_reread_stable();
    if (dut.u_checker.fail_count == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog/coef_bram.sv
// Coefficient memory and ready flag
`timescale 1ns/1ps
`default_nettype none

`include "gat_cfg.svh"

module coef_bram (
  input  wire logic                    clk,
  input  wire logic                    rst_n,
  input  wire logic                    coef_vld_i,
  input  wire gat_pkg::coef_item_t     coef_i,
  input  wire logic [`GAT_NODE_AW-1:0] coef_addr_i,
  output gat_pkg::coef_t               coef_data_o,
  output logic                         gat_ready_o
);

  localparam int LAST_NODE = `GAT_TOTAL_NODES - 1;

  gat_pkg::coef_t mem [`GAT_TOTAL_NODES];

  // Layer writes, host reads one cycle later
  always_ff @(posedge clk) begin
    if (coef_vld_i) begin
      mem[coef_i.node] <= coef_i.coef;
    end
    coef_data_o <= mem[coef_addr_i];
  end

  // Nodes arrive in order, so the last node closes the layer
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      gat_ready_o <= 1'b0;
    end else if (coef_vld_i && (coef_i.node == LAST_NODE)) begin
      gat_ready_o <= 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- verilog/dmvm_stage.sv
// Attention score and leaky ReLU
`timescale 1ns/1ps
`default_nettype none

`include "gat_cfg.svh"

module dmvm_stage (
  input  wire logic           clk,
  input  wire logic           rst_n,
  input  wire gat_pkg::avec_arr_t avec_i,
  input  wire logic           wh_vld_i,
  input  wire gat_pkg::wh_item_t  wh_i,
  output logic                coef_vld_o,
  output gat_pkg::coef_item_t coef_o
);

  localparam int FO = `GAT_FEAT_OUT;

  gat_pkg::coef_t          left_d;
  gat_pkg::coef_t          right_d;

  gat_pkg::coef_t          left_q;
  gat_pkg::coef_t          right_q;
  logic [`GAT_NODE_AW-1:0] node_q;
  logic                    centre_q;
  logic                    vld_q;

  gat_pkg::coef_t          centre_score;
  gat_pkg::coef_t          score_sum;

  // Dot products wrap at coefficient width
  always_comb begin
    left_d  = '0;
    right_d = '0;
    for (int f = 0; f < FO; f++) begin
      left_d  = left_d + avec_i[f] * wh_i.wh[f];
      right_d = right_d + avec_i[FO + f] * wh_i.wh[f];
    end
  end

  // ==================================================
  // Stage 1
  // ==================================================
  always_ff @(posedge clk) begin
    if (wh_vld_i) begin
      left_q   <= left_d;
      right_q  <= right_d;
      node_q   <= wh_i.node;
      centre_q <= wh_i.info.centre;
    end
    // Latest flagged node is the centre of the running subgraph
    if (vld_q && centre_q) begin
      centre_score <= left_q;
    end
  end

  // A centre node pairs with its own left score
  assign score_sum = (centre_q ? left_q : centre_score) + right_q;

  // ==================================================
  // Stage 2
  // ==================================================
  always_ff @(posedge clk) begin
    if (vld_q) begin
      coef_o.node <= node_q;
      if (score_sum < 0) begin
        coef_o.coef <= score_sum >>> `GAT_LRELU_SHIFT;
      end else begin
        coef_o.coef <= score_sum;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vld_q      <= 1'b0;
      coef_vld_o <= 1'b0;
    end else begin
      vld_q      <= wh_vld_i;
      coef_vld_o <= vld_q;
    end
  end

endmodule

`default_nettype wire

//--- verilog/feature_bram.sv
// Sparse feature and node info memories
`timescale 1ns/1ps
`default_nettype none

`include "gat_cfg.svh"

module feature_bram (
  input  wire logic                    clk,
  input  wire gat_pkg::h_wr_t          h_wr_i,
  input  wire gat_pkg::info_wr_t       info_wr_i,
  input  wire logic [`GAT_NNZ_AW-1:0]  h_addr_i,
  output gat_pkg::h_entry_t            h_data_o,
  input  wire logic [`GAT_NODE_AW-1:0] info_addr_i,
  output gat_pkg::node_info_t          info_data_o
);

  gat_pkg::h_entry_t   h_mem    [`GAT_NNZ_DEPTH];
  gat_pkg::node_info_t info_mem [`GAT_TOTAL_NODES];

  // Nonzeros of all rows, packed in node order
  always_ff @(posedge clk) begin
    if (h_wr_i.en) begin
      h_mem[h_wr_i.addr] <= h_wr_i.data;
    end
    h_data_o <= h_mem[h_addr_i];
  end

  // Row length, subgraph size and centre flag per node
  always_ff @(posedge clk) begin
    if (info_wr_i.en) begin
      info_mem[info_wr_i.addr] <= info_wr_i.data;
    end
    info_data_o <= info_mem[info_addr_i];
  end

endmodule

`default_nettype wire

//--- verilog/gat_pkg.sv
// GAT shared types
`default_nettype none

`include "gat_cfg.svh"

package gat_pkg;

  // Scalar types, signed so packed array elements stay signed
  typedef logic signed [`GAT_DATA_W-1:0] data_t;
  typedef logic signed [`GAT_WH_W-1:0]   wh_t;
  typedef logic signed [`GAT_COEF_W-1:0] coef_t;

  // W indexed [f][k], a holds left half then right half
  typedef data_t [`GAT_FEAT_OUT-1:0][`GAT_FEAT_IN-1:0] wgt_arr_t;
  typedef data_t [2*`GAT_FEAT_OUT-1:0]                 avec_arr_t;

  // One nonzero of a sparse feature row
  typedef struct packed {
    data_t                  val;
    logic [`GAT_COL_W-1:0]  col;
  } h_entry_t;

  typedef struct packed {
    logic [`GAT_ROW_LEN_W-1:0] row_len;
    logic [`GAT_SG_W-1:0]      sg_size;
    logic                      centre;
  } node_info_t;

  // ==================================================
  // Host write ports
  // ==================================================
  typedef struct packed {
    logic                   en;
    logic [`GAT_NNZ_AW-1:0] addr;
    h_entry_t               data;
  } h_wr_t;

  typedef struct packed {
    logic                    en;
    logic [`GAT_NODE_AW-1:0] addr;
    node_info_t              data;
  } info_wr_t;

  typedef struct packed {
    logic                   en;
    logic [`GAT_WGT_AW-1:0] addr;
    data_t                  data;
  } wgt_wr_t;

  // Stage payloads
  typedef struct packed {
    logic [`GAT_NODE_AW-1:0]    node;
    node_info_t                 info;
    wh_t [`GAT_FEAT_OUT-1:0]    wh;
  } wh_item_t;

  typedef struct packed {
    logic [`GAT_NODE_AW-1:0] node;
    coef_t                   coef;
  } coef_item_t;

endpackage

`default_nettype wire

//--- verilog/gat_top.sv
// GAT layer top level
`timescale 1ns/1ps
`default_nettype none

`include "gat_cfg.svh"

module gat_top (
  input  wire logic                    clk,
  input  wire logic                    rst_n,
  input  wire gat_pkg::h_wr_t          h_wr_i,
  input  wire gat_pkg::info_wr_t       info_wr_i,
  input  wire gat_pkg::wgt_wr_t        wgt_wr_i,
  input  wire logic                    h_load_done_i,
  input  wire logic                    info_load_done_i,
  input  wire logic                    wgt_load_done_i,
  input  wire logic [`GAT_NODE_AW-1:0] coef_addr_i,
  output gat_pkg::coef_t               coef_data_o,
  output logic                         gat_ready_o
);

  gat_pkg::wgt_arr_t       wgt;
  gat_pkg::avec_arr_t      avec;
  logic                    weights_ready;
  logic                    spmm_start;

  logic [`GAT_NNZ_AW-1:0]  h_addr;
  gat_pkg::h_entry_t       h_data;
  logic [`GAT_NODE_AW-1:0] info_addr;
  gat_pkg::node_info_t     info_data;

  logic                    wh_vld;
  gat_pkg::wh_item_t       wh;
  logic                    coef_vld;
  gat_pkg::coef_item_t     coef;

  // SpMM waits for weights and both feature memories
  assign spmm_start = weights_ready & h_load_done_i & info_load_done_i;

  weight_loader u_weight_loader (
    .clk             (clk),
    .rst_n           (rst_n),
    .wgt_wr_i        (wgt_wr_i),
    .wgt_load_done_i (wgt_load_done_i),
    .wgt_o           (wgt),
    .avec_o          (avec),
    .weights_ready_o (weights_ready)
  );

  feature_bram u_feature_bram (
    .clk         (clk),
    .h_wr_i      (h_wr_i),
    .info_wr_i   (info_wr_i),
    .h_addr_i    (h_addr),
    .h_data_o    (h_data),
    .info_addr_i (info_addr),
    .info_data_o (info_data)
  );

  spmm_stage u_spmm_stage (
    .clk         (clk),
    .rst_n       (rst_n),
    .start_i     (spmm_start),
    .wgt_i       (wgt),
    .h_addr_o    (h_addr),
    .h_data_i    (h_data),
    .info_addr_o (info_addr),
    .info_data_i (info_data),
    .wh_vld_o    (wh_vld),
    .wh_o        (wh)
  );

  dmvm_stage u_dmvm_stage (
    .clk        (clk),
    .rst_n      (rst_n),
    .avec_i     (avec),
    .wh_vld_i   (wh_vld),
    .wh_i       (wh),
    .coef_vld_o (coef_vld),
    .coef_o     (coef)
  );

  coef_bram u_coef_bram (
    .clk         (clk),
    .rst_n       (rst_n),
    .coef_vld_i  (coef_vld),
    .coef_i      (coef),
    .coef_addr_i (coef_addr_i),
    .coef_data_o (coef_data_o),
    .gat_ready_o (gat_ready_o)
  );

endmodule

`default_nettype wire

//--- verilog/spmm_stage.sv
// Sparse row times W
`timescale 1ns/1ps
`default_nettype none

`include "gat_cfg.svh"

module spmm_stage (
  input  wire logic                     clk,
  input  wire logic                     rst_n,
  input  wire logic                     start_i,
  input  wire gat_pkg::wgt_arr_t        wgt_i,
  output logic [`GAT_NNZ_AW-1:0]        h_addr_o,
  input  wire gat_pkg::h_entry_t        h_data_i,
  output logic [`GAT_NODE_AW-1:0]       info_addr_o,
  input  wire gat_pkg::node_info_t      info_data_i,
  output logic                          wh_vld_o,
  output gat_pkg::wh_item_t             wh_o
);

  localparam int LAST_NODE = `GAT_TOTAL_NODES - 1;

  typedef enum logic [1:0] {
    S_IDLE,
    S_INFO,
    S_ACC,
    S_DONE
  } state_t;

  state_t                         state;
  logic [`GAT_NODE_AW-1:0]        node_cnt;
  logic [`GAT_NNZ_AW-1:0]         nnz_ptr;
  logic [`GAT_ROW_LEN_W-1:0]      nz_cnt;
  gat_pkg::wh_t [`GAT_FEAT_OUT-1:0] acc;

  logic                           consume;
  logic                           emit;

  // Info data stays valid for the whole node since its address is held
  assign consume = (state == S_ACC) && (nz_cnt != info_data_i.row_len);
  assign emit    = (state == S_ACC) && (nz_cnt == info_data_i.row_len);

  assign info_addr_o = node_cnt;
  // Prefetch the next nonzero while the current one is consumed
  assign h_addr_o    = consume ? nnz_ptr + 1'b1 : nnz_ptr;

  // ==================================================
  // Node walk
  // ==================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= S_IDLE;
      node_cnt <= '0;
      nnz_ptr  <= '0;
      nz_cnt   <= '0;
      wh_vld_o <= 1'b0;
    end else begin
      wh_vld_o <= emit;
      case (state)
        S_IDLE: begin
          if (start_i) begin
            state <= S_INFO;
          end
        end
        S_INFO: begin
          state <= S_ACC;
        end
        S_ACC: begin
          if (consume) begin
            nz_cnt  <= nz_cnt + 1'b1;
            nnz_ptr <= nnz_ptr + 1'b1;
          end else begin
            nz_cnt <= '0;
            if (node_cnt == LAST_NODE) begin
              state <= S_DONE;
            end else begin
              node_cnt <= node_cnt + 1'b1;
              state    <= S_INFO;
            end
          end
        end
        default: begin
          state <= S_DONE;
        end
      endcase
    end
  end

  // ==================================================
  // Accumulators
  // ==================================================
  always_ff @(posedge clk) begin
    for (int f = 0; f < `GAT_FEAT_OUT; f++) begin
      if (consume) begin
        acc[f] <= acc[f] + h_data_i.val * wgt_i[f][h_data_i.col];
      end else begin
        acc[f] <= '0;
      end
    end
    if (emit) begin
      wh_o.node <= node_cnt;
      wh_o.info <= info_data_i;
      wh_o.wh   <= acc;
    end
  end

endmodule

`default_nettype wire

//--- verilog/weight_loader.sv
// Weight memory and register loader
`timescale 1ns/1ps
`default_nettype none

`include "gat_cfg.svh"

module weight_loader (
  input  wire logic           clk,
  input  wire logic           rst_n,
  input  wire gat_pkg::wgt_wr_t wgt_wr_i,
  input  wire logic           wgt_load_done_i,
  output gat_pkg::wgt_arr_t   wgt_o,
  output gat_pkg::avec_arr_t  avec_o,
  output logic                weights_ready_o
);

  localparam int LAST_ADDR = `GAT_WGT_DEPTH - 1;
  localparam int AVEC_BASE = `GAT_FEAT_OUT * `GAT_FEAT_IN;
  localparam int KW        = $clog2(`GAT_FEAT_IN);
  localparam int FW        = $clog2(`GAT_FEAT_OUT);
  localparam int AVW       = $clog2(2 * `GAT_FEAT_OUT);

  gat_pkg::data_t         mem [`GAT_WGT_DEPTH];

  logic [`GAT_WGT_AW-1:0] rd_addr;
  logic                   issue_done;
  logic                   rd_en;

  gat_pkg::data_t         rd_data;
  logic [`GAT_WGT_AW-1:0] st_addr;
  logic                   st_vld;
  logic                   st_last;

  // One read per cycle until the whole memory has been issued
  assign rd_en = wgt_load_done_i && !issue_done;

  // ==================================================
  // Memory
  // ==================================================
  always_ff @(posedge clk) begin
    if (wgt_wr_i.en) begin
      mem[wgt_wr_i.addr] <= wgt_wr_i.data;
    end
    if (rd_en) begin
      rd_data <= mem[rd_addr];
      st_addr <= rd_addr;
    end
  end

  // ==================================================
  // Read sequencing
  // ==================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_addr         <= '0;
      issue_done      <= 1'b0;
      st_vld          <= 1'b0;
      st_last         <= 1'b0;
      weights_ready_o <= 1'b0;
    end else begin
      st_vld <= rd_en;
      if (rd_en) begin
        rd_addr <= rd_addr + 1'b1;
        if (rd_addr == LAST_ADDR) begin
          issue_done <= 1'b1;
        end
      end
      st_last <= st_vld && (st_addr == LAST_ADDR);
      if (st_last) begin
        weights_ready_o <= 1'b1;
      end
    end
  end

  // Address f*16+k goes to W[f][k], the tail to the a vector
  always_ff @(posedge clk) begin
    if (st_vld) begin
      if (st_addr < AVEC_BASE) begin
        wgt_o[st_addr[KW +: FW]][st_addr[KW-1:0]] <= rd_data;
      end else begin
        avec_o[st_addr[AVW-1:0]] <= rd_data;
      end
    end
  end

endmodule

`default_nettype wire
